/* logic/cache_biu_pkg.sv */
package cache_biu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // bus word width, also the address width
  parameter int XLEN = 32;

  ////////////////////////////////////////
  // basic types
  ////////////////////////////////////////

  typedef logic [XLEN-1:0] word_t; // one bus data word
  typedef logic [XLEN-1:0] adr_t;  // byte address

  ////////////////////////////////////////
  // way commands
  ////////////////////////////////////////

  // issued by the sequencer and held until biucmd_ack
  typedef enum logic [1:0]
  {
    BIUCMD_NOP,      // nothing to do
    BIUCMD_READWAY,  // line fill from memory
    BIUCMD_WRITEWAY  // write-back of an evicted line
  } biucmd_e;

  ////////////////////////////////////////
  // burst types
  ////////////////////////////////////////

  // wrap types stay inside the line, critical word first
  // incr types walk upward from the start address
  typedef enum logic [2:0]
  {
    SINGLE, // one word
    INCR,   // open length, handled as one word here
    WRAP4,  // 4 words, wrapping
    INCR4,  // 4 words, ascending
    WRAP8,  // 8 words, wrapping
    INCR8   // 8 words, ascending
  } biu_type_e;

  // the line itself is BURST_LEN words, so its width
  // is a module parameter matter and not set here

  // a fill uses the WRAP type matching BURST_LEN,
  // an eviction the INCR type of the same length

  // 4-word lines: WRAP4 / INCR4
  // 8-word lines: WRAP8 / INCR8

  // SINGLE and INCR are kept for completeness of
  // the encoding, the controller never issues them

endpackage

/* logic/cache_mem_seq.sv */
module cache_mem_seq #(
  parameter int BURST_LEN = 4
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              fill_req_i,   // line fill wanted
  input  logic                              evict_req_i,  // write-back wanted
  input  cache_biu_pkg::adr_t               line_adr_i,   // requested word address
  input  logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] evict_line_i,

  output cache_biu_pkg::biucmd_e            biucmd_o,     // held until ack
  input  logic                              biucmd_ack_i,
  output cache_biu_pkg::adr_t               adr_o,
  output logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] evict_line_o,
  input  logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] biu_line_i,  // merged fill line
  input  logic                              biu_err_i,

  output logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] line_o,  // valid with done_o
  output logic                              done_o,
  output logic                              err_o
);

  localparam int LINE_W = BURST_LEN * cache_biu_pkg::XLEN;

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  typedef enum logic [1:0] {IDLE, FILL, EVICT, DONE} seq_state_e;

  seq_state_e          state;
  logic                err_q;      // sticky over one operation
  cache_biu_pkg::adr_t adr_q;
  logic [LINE_W-1:0]   evict_q;
  logic [LINE_W-1:0]   line_q;

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state <= IDLE;
      err_q <= 1'b0;
    end
    else
    begin
      unique case (state)
        IDLE:
          if (evict_req_i) // eviction wins a tie
          begin
            state <= EVICT;
            err_q <= 1'b0;
          end
          else if (fill_req_i)
          begin
            state <= FILL;
            err_q <= 1'b0;
          end
        FILL, EVICT:
        begin
          err_q <= err_q | biu_err_i; // collect any bus error
          if (biucmd_ack_i) state <= DONE;
        end
        DONE:    state <= IDLE; // one-cycle done
        default: state <= IDLE;
      endcase
    end

  // request payload, latched once in idle
  always_ff @(posedge clk_i)
  begin
    if (state == IDLE && (fill_req_i || evict_req_i))
    begin
      adr_q   <= line_adr_i;
      evict_q <= evict_line_i;
    end
    if (state == FILL && biucmd_ack_i) line_q <= biu_line_i; // merged line incl. last word
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  always_comb
    unique case (state)
      FILL:    biucmd_o = cache_biu_pkg::BIUCMD_READWAY;
      EVICT:   biucmd_o = cache_biu_pkg::BIUCMD_WRITEWAY;
      default: biucmd_o = cache_biu_pkg::BIUCMD_NOP;
    endcase

  assign adr_o        = adr_q;
  assign evict_line_o = evict_q;
  assign line_o       = line_q;
  assign done_o       = (state == DONE);
  assign err_o        = (state == DONE) & err_q; // only meaningful with done

endmodule

/* logic/cache_biu_ctrl.sv */
module cache_biu_ctrl #(
  parameter int BURST_LEN = 4
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // sequencer side
  input  cache_biu_pkg::biucmd_e            biucmd_i,
  output logic                              biucmd_ack_o,   // last word or error
  input  cache_biu_pkg::adr_t               adr_i,
  input  logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] evict_line_i,
  input  logic                              req_i,          // fill in progress
  output logic                              in_biubuffer_o,
  output logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] biu_line_o,

  // bridge side
  output logic                              biu_stb_o,      // burst request
  input  logic                              biu_stb_ack_i,  // request taken
  input  logic                              biu_d_ack_i,    // next write word please
  output cache_biu_pkg::adr_t               biu_adri_o,     // burst start address
  input  cache_biu_pkg::adr_t               biu_adro_i,     // address of current word
  output logic                              biu_we_o,
  output cache_biu_pkg::word_t              biu_d_o,
  input  cache_biu_pkg::word_t              biu_q_i,
  output cache_biu_pkg::biu_type_e          biu_type_o,
  input  logic                              biu_ack_i,
  input  logic                              biu_err_i
);

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  localparam int WORD_BYTES = cache_biu_pkg::XLEN / 8;
  localparam int BYTE_BITS  = $clog2(WORD_BYTES);     // byte offset in a word
  localparam int OFFS_BITS  = $clog2(BURST_LEN);      // word offset in a line
  localparam int LINE_BITS  = BYTE_BITS + OFFS_BITS;  // byte offset in a line
  localparam int LINE_W     = BURST_LEN * cache_biu_pkg::XLEN;

  localparam cache_biu_pkg::biu_type_e FILL_TYPE =
    (BURST_LEN == 8) ? cache_biu_pkg::WRAP8 : cache_biu_pkg::WRAP4;
  localparam cache_biu_pkg::biu_type_e EVICT_TYPE =
    (BURST_LEN == 8) ? cache_biu_pkg::INCR8 : cache_biu_pkg::INCR4;

  ////////////////////////////////////////
  // variables
  ////////////////////////////////////////

  typedef enum logic [1:0] {IDLE, WAIT4BIU, BURST} biu_state_e;

  biu_state_e                state;
  logic [OFFS_BITS-1:0]      burst_cnt;   // words left minus one
  logic [LINE_W-1:0]         biubuffer;   // line shift buffer
  logic [BURST_LEN-1:0]      biubuffer_valid;
  logic [OFFS_BITS-1:0]      dat_offset;  // word asked for by the cache
  logic [OFFS_BITS-1:0]      ret_offset;  // word coming back now
  logic                      line_hit;

  cache_biu_pkg::adr_t       biu_adri_hold;
  logic                      biu_we_hold;
  cache_biu_pkg::word_t      biu_d_hold;
  cache_biu_pkg::biu_type_e  biu_type_hold;

  ////////////////////////////////////////
  // way transfer FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state           <= IDLE;
      burst_cnt       <= '0;
      biubuffer_valid <= '0;
    end
    else
    begin
      unique case (state)
        IDLE:
        begin
          burst_cnt       <= OFFS_BITS'(BURST_LEN - 1);
          biubuffer_valid <= '0; // fresh fill
          if (biucmd_i != cache_biu_pkg::BIUCMD_NOP)
            state <= biu_stb_ack_i ? BURST : WAIT4BIU; // bridge busy, stretch strobe
        end
        WAIT4BIU:
          if (biu_stb_ack_i) state <= BURST;
        BURST:
        begin
          if (biu_ack_i)
          begin
            burst_cnt <= burst_cnt - 1'b1;
            if (!biu_we_hold) biubuffer_valid[ret_offset] <= 1'b1;
          end
          if (biu_err_i || (burst_cnt == '0 && biu_ack_i)) state <= IDLE; // done or aborted
        end
        default: state <= IDLE;
      endcase
    end

  // line data: load on evict, merge on fill, shift on write-back
  always_ff @(posedge clk_i)
    unique case (state)
      IDLE:
        if (biucmd_i == cache_biu_pkg::BIUCMD_WRITEWAY)
          biubuffer <= evict_line_i >> cache_biu_pkg::XLEN; // word 0 goes out with the strobe
      BURST:
        if (!biu_we_hold)
        begin
          if (biu_ack_i) biubuffer[ret_offset*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] <= biu_q_i;
        end
        else if (biu_d_ack_i)
          biubuffer <= biubuffer >> cache_biu_pkg::XLEN; // next word to bridge
      default: ;
    endcase

  // request fields, kept while the strobe waits
  always_ff @(posedge clk_i)
    if (state == IDLE)
    begin
      biu_adri_hold <= biu_adri_o;
      biu_we_hold   <= biu_we_o;
      biu_d_hold    <= biu_d_o;
      biu_type_hold <= biu_type_o;
    end

  ////////////////////////////////////////
  // in-buffer check and line merge
  ////////////////////////////////////////

  assign dat_offset = adr_i[BYTE_BITS +: OFFS_BITS];
  assign ret_offset = biu_adro_i[BYTE_BITS +: OFFS_BITS];
  assign line_hit   = (biu_adri_hold[cache_biu_pkg::XLEN-1:LINE_BITS] ==
                       adr_i[cache_biu_pkg::XLEN-1:LINE_BITS]);

  assign in_biubuffer_o = req_i & line_hit & biubuffer_valid[dat_offset];

  // buffer plus the word arriving this cycle
  always_comb
  begin
    biu_line_o = biubuffer;
    if (biu_ack_i && !biu_we_hold)
      biu_line_o[ret_offset*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] = biu_q_i;
  end

  assign biucmd_ack_o = (state == BURST) & ((burst_cnt == '0 & biu_ack_i) | biu_err_i);

  ////////////////////////////////////////
  // request to bridge, combinational
  ////////////////////////////////////////

  always_comb
  begin
    biu_stb_o  = 1'b0;
    biu_adri_o = biu_adri_hold;
    biu_we_o   = biu_we_hold;
    biu_d_o    = biu_d_hold;
    biu_type_o = biu_type_hold;
    unique case (state)
      IDLE:
        unique case (biucmd_i)
          cache_biu_pkg::BIUCMD_READWAY:
          begin
            biu_stb_o  = 1'b1;
            biu_adri_o = {adr_i[cache_biu_pkg::XLEN-1:BYTE_BITS], {BYTE_BITS{1'b0}}}; // critical word
            biu_we_o   = 1'b0;
            biu_d_o    = '0;
            biu_type_o = FILL_TYPE;
          end
          cache_biu_pkg::BIUCMD_WRITEWAY:
          begin
            biu_stb_o  = 1'b1;
            biu_adri_o = {adr_i[cache_biu_pkg::XLEN-1:LINE_BITS], {LINE_BITS{1'b0}}}; // line base
            biu_we_o   = 1'b1;
            biu_d_o    = evict_line_i[cache_biu_pkg::XLEN-1:0];
            biu_type_o = EVICT_TYPE;
          end
          default: ; // nop, no request
        endcase
      WAIT4BIU: biu_stb_o = 1'b1;                  // stretch, fields from hold
      BURST:    biu_d_o   = biubuffer[cache_biu_pkg::XLEN-1:0];
      default:  ;
    endcase
  end

endmodule

/* logic/biu_burst_bridge.sv */
module biu_burst_bridge #(
  parameter int BURST_LEN = 4
)
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // burst side
  input  logic                      biu_stb_i,
  output logic                      biu_stb_ack_o,  // high while idle
  input  cache_biu_pkg::adr_t       biu_adri_i,
  input  logic                      biu_we_i,
  input  cache_biu_pkg::word_t      biu_d_i,
  input  cache_biu_pkg::biu_type_e  biu_type_i,
  output logic                      biu_d_ack_o,    // pulls next write word
  output cache_biu_pkg::adr_t       biu_adro_o,
  output cache_biu_pkg::word_t      biu_q_o,
  output logic                      biu_ack_o,
  output logic                      biu_err_o,

  // memory side, one word at a time
  output logic                      mem_req_o,
  output cache_biu_pkg::adr_t       mem_adr_o,
  output logic                      mem_we_o,
  output cache_biu_pkg::word_t      mem_d_o,
  input  cache_biu_pkg::word_t      mem_q_i,
  input  logic                      mem_ack_i,
  input  logic                      mem_err_i
);

  localparam int WORD_BYTES = cache_biu_pkg::XLEN / 8;
  localparam int BYTE_BITS  = $clog2(WORD_BYTES);
  localparam int OFFS_BITS  = $clog2(BURST_LEN); // bursts never exceed a line

  typedef enum logic {IDLE, XFER} brg_state_e;

  brg_state_e           state;
  logic [OFFS_BITS-1:0] cnt;      // words left minus one
  logic [2:0]           len_m1;   // burst length from type, minus one
  logic                 is_wrap;
  logic                 wrap_q;
  logic                 we_q;
  cache_biu_pkg::adr_t  adr_q;
  cache_biu_pkg::adr_t  adr_nxt;
  cache_biu_pkg::word_t d_q;

  // decode burst type
  always_comb
    unique case (biu_type_i)
      cache_biu_pkg::WRAP4, cache_biu_pkg::INCR4: len_m1 = 3'd3;
      cache_biu_pkg::WRAP8, cache_biu_pkg::INCR8: len_m1 = 3'd7;
      default:                                    len_m1 = 3'd0; // single / open incr
    endcase

  assign is_wrap = (biu_type_i == cache_biu_pkg::WRAP4) || (biu_type_i == cache_biu_pkg::WRAP8);

  // next word address, wrap keeps the line bits
  always_comb
  begin
    adr_nxt = adr_q + cache_biu_pkg::adr_t'(WORD_BYTES);
    if (wrap_q)
    begin
      adr_nxt = adr_q;
      adr_nxt[BYTE_BITS +: OFFS_BITS] = adr_q[BYTE_BITS +: OFFS_BITS] + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state <= IDLE;
      cnt   <= '0;
    end
    else
    begin
      unique case (state)
        IDLE:
          if (biu_stb_i)
          begin
            state <= XFER;
            cnt   <= OFFS_BITS'(len_m1);
          end
        XFER:
          if (mem_err_i) state <= IDLE;       // drop rest of burst
          else if (mem_ack_i)
          begin
            if (cnt == '0) state <= IDLE;
            cnt <= cnt - 1'b1;
          end
        default: state <= IDLE;
      endcase
    end

  // burst payload
  always_ff @(posedge clk_i)
    if (state == IDLE && biu_stb_i)
    begin
      adr_q  <= biu_adri_i;
      we_q   <= biu_we_i;
      d_q    <= biu_d_i;     // first write word comes with strobe
      wrap_q <= is_wrap;
    end
    else if (state == XFER && mem_ack_i)
    begin
      adr_q <= adr_nxt;
      if (biu_d_ack_o) d_q <= biu_d_i;
    end

  assign biu_stb_ack_o = (state == IDLE);
  assign biu_ack_o     = (state == XFER) & mem_ack_i;
  assign biu_err_o     = (state == XFER) & mem_err_i;
  assign biu_d_ack_o   = (state == XFER) & mem_ack_i & we_q & (cnt != '0);
  assign biu_adro_o    = adr_q;
  assign biu_q_o       = mem_q_i; // valid with biu_ack_o

  assign mem_req_o = (state == XFER);
  assign mem_adr_o = adr_q;
  assign mem_we_o  = we_q;
  assign mem_d_o   = d_q;

endmodule

/* logic/cache_biu_top.sv */
module cache_biu_top #(
  parameter int BURST_LEN = 4
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              fill_req_i,
  input  logic                              evict_req_i,
  input  cache_biu_pkg::adr_t               line_adr_i,
  input  logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] evict_line_i,
  output logic [BURST_LEN*cache_biu_pkg::XLEN-1:0] line_o,
  output logic                              done_o,
  output logic                              err_o,
  output logic                              in_biubuffer_o,
  output logic                              mem_req_o,
  output cache_biu_pkg::adr_t               mem_adr_o,
  output logic                              mem_we_o,
  output cache_biu_pkg::word_t              mem_d_o,
  input  cache_biu_pkg::word_t              mem_q_i,
  input  logic                              mem_ack_i,
  input  logic                              mem_err_i
);

  localparam int LINE_W = BURST_LEN * cache_biu_pkg::XLEN;

  cache_biu_pkg::biucmd_e   biucmd;
  cache_biu_pkg::adr_t      seq_adr;
  logic [LINE_W-1:0]        evict_line;
  logic [LINE_W-1:0]        biu_line;
  logic                     biucmd_ack;
  logic                     fill_active;  // qualifies the in-buffer check
  logic                     biu_stb, biu_stb_ack, biu_we, biu_d_ack, biu_ack, biu_err;
  cache_biu_pkg::adr_t      biu_adri, biu_adro;
  cache_biu_pkg::word_t     biu_d, biu_q;
  cache_biu_pkg::biu_type_e biu_type;

  assign fill_active = (biucmd == cache_biu_pkg::BIUCMD_READWAY);

  cache_mem_seq #(.BURST_LEN(BURST_LEN)) u_seq (
    .clk_i, .rst_ni, .fill_req_i, .evict_req_i, .line_adr_i, .evict_line_i,
    .biucmd_o(biucmd), .biucmd_ack_i(biucmd_ack), .adr_o(seq_adr),
    .evict_line_o(evict_line), .biu_line_i(biu_line), .biu_err_i(biu_err),
    .line_o, .done_o, .err_o);

  cache_biu_ctrl #(.BURST_LEN(BURST_LEN)) u_ctrl (
    .clk_i, .rst_ni, .biucmd_i(biucmd), .biucmd_ack_o(biucmd_ack), .adr_i(seq_adr),
    .evict_line_i(evict_line), .req_i(fill_active), .in_biubuffer_o, .biu_line_o(biu_line),
    .biu_stb_o(biu_stb), .biu_stb_ack_i(biu_stb_ack), .biu_d_ack_i(biu_d_ack),
    .biu_adri_o(biu_adri), .biu_adro_i(biu_adro), .biu_we_o(biu_we), .biu_d_o(biu_d),
    .biu_q_i(biu_q), .biu_type_o(biu_type), .biu_ack_i(biu_ack), .biu_err_i(biu_err));

  biu_burst_bridge #(.BURST_LEN(BURST_LEN)) u_bridge (
    .clk_i, .rst_ni, .biu_stb_i(biu_stb), .biu_stb_ack_o(biu_stb_ack),
    .biu_adri_i(biu_adri), .biu_we_i(biu_we), .biu_d_i(biu_d), .biu_type_i(biu_type),
    .biu_d_ack_o(biu_d_ack), .biu_adro_o(biu_adro), .biu_q_o(biu_q), .biu_ack_o(biu_ack),
    .biu_err_o(biu_err), .mem_req_o, .mem_adr_o, .mem_we_o, .mem_d_o, .mem_q_i,
    .mem_ack_i, .mem_err_i);

endmodule

/* sim/cache_biu_properties.sv */
module cache_biu_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     biu_stb_o,
  input logic                     biu_stb_ack_i,
  input cache_biu_pkg::adr_t      biu_adri_o,
  input logic                     biu_we_o,
  input cache_biu_pkg::word_t     biu_d_o,
  input cache_biu_pkg::biu_type_e biu_type_o,
  input logic                     biucmd_ack_o,
  input logic                     biu_ack_i,
  input logic                     biu_err_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic burst_open; // strobe taken and way command not yet acked

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      burst_open <= 1'b0;
    else if (biu_stb_o && biu_stb_ack_i)
      burst_open <= 1'b1; // bridge took the burst
    else if (biucmd_ack_o)
      burst_open <= 1'b0;

  // a waiting strobe keeps all its fields
  stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adri_o) && $stable(biu_we_o)
      && $stable(biu_d_o) && $stable(biu_type_o))
    else $error("biu_stb dropped or changed its fields before biu_stb_ack");

  cmd_ack_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biucmd_ack_o |-> burst_open) // one ack per taken burst
    else $error("biucmd_ack without a burst taken by the bridge");

  // bridge busy stands for its memory request until the word ends
  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !biu_stb_ack_i && !biu_ack_i && !biu_err_i |=> !biu_stb_ack_i)
    else $error("memory request dropped before an acknowledge");

endmodule

/* sim/cache_biu_tb.sv */
module cache_biu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BURST_LEN  = 4;
  localparam int LINE_W     = BURST_LEN * cache_biu_pkg::XLEN;
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int TIMEOUT    = 200;    // cycles per wait
  localparam int MEM_WORDS  = 16384;  // 64 KiB model, patterns stay below
  localparam int SIG_MEM_REQ = 0;
  localparam int SIG_MEM_ACK = 1;
  localparam int SIG_DONE    = 2;

  logic clk_i, rst_ni, fill_req_i, evict_req_i;
  cache_biu_pkg::adr_t  line_adr_i, mem_adr_o;
  logic [LINE_W-1:0]    evict_line_i, line_o;
  logic done_o, err_o, in_biubuffer_o, mem_req_o, mem_we_o, mem_ack_i, mem_err_i;
  cache_biu_pkg::word_t mem_d_o, mem_q_i;

  cache_biu_pkg::word_t mem_words [MEM_WORDS];
  cache_biu_pkg::adr_t  adr_log [$];   // every word the memory answered
  cache_biu_pkg::word_t data_log [$];  // write data in arrival order
  cache_biu_pkg::adr_t  err_adr;
  logic                 err_adr_valid;
  int                   ops_run;

  cache_biu_top #(.BURST_LEN(BURST_LEN)) u_cache_biu_top (
    .clk_i, .rst_ni, .fill_req_i, .evict_req_i, .line_adr_i, .evict_line_i,
    .line_o, .done_o, .err_o, .in_biubuffer_o, .mem_req_o, .mem_adr_o, .mem_we_o,
    .mem_d_o, .mem_q_i, .mem_ack_i, .mem_err_i);

  bind cache_biu_ctrl cache_biu_properties u_props (
    .clk_i, .rst_ni, .biu_stb_o, .biu_stb_ack_i, .biu_adri_o, .biu_we_o, .biu_d_o,
    .biu_type_o, .biucmd_ack_o, .biu_ack_i, .biu_err_i);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period
  end

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  initial
  begin : memory_model
    int                  delay_left;
    cache_biu_pkg::adr_t a;
    delay_left = -1; // no word pending
    mem_q_i    = '0;
    mem_ack_i  = 1'b0;
    mem_err_i  = 1'b0;
    void'($urandom(32'h4398));
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      a = cache_biu_pkg::adr_t'(i * 4);
      mem_words[i] = {~a[15:0], a[15:0]}; // inverted low half on top
    end
    forever
    begin
      @(posedge clk_i);
      #2;
      mem_ack_i = 1'b0;
      mem_err_i = 1'b0;
      if (mem_req_o)
      begin
        if (delay_left < 0) delay_left = int'($urandom % 4); // 0..3 cycles
        if (delay_left == 0)
        begin
          if (err_adr_valid && mem_adr_o == err_adr)
            mem_err_i = 1'b1;
          else if (mem_we_o)
          begin
            mem_ack_i = 1'b1;
            mem_words[mem_adr_o[15:2]] = mem_d_o;
            data_log.push_back(mem_d_o);
          end
          else
          begin
            mem_ack_i = 1'b1;
            mem_q_i   = mem_words[mem_adr_o[15:2]];
          end
          adr_log.push_back(mem_adr_o);
          delay_left = -1;
        end
        else
          delay_left--;
      end
    end
  end

  ////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_line(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                            input string what);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                              $time, what, got, exp));
  endtask

  task automatic check_adr(input cache_biu_pkg::adr_t got, input cache_biu_pkg::adr_t exp,
                           input string what);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                              $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                              $time, what, got, exp));
  endtask

  function automatic logic sig_value(input int which);
    case (which)
      SIG_MEM_REQ: return mem_req_o;
      SIG_MEM_ACK: return mem_ack_i;
      default:     return done_o;
    endcase
  endfunction

  // call at a falling edge, checks before it moves on
  task automatic wait_for_high(input int which, input string what);
    int cycles;
    cycles = 0;
    while (!sig_value(which))
    begin
      if (cycles == TIMEOUT)
        stop_on_error($sformatf("timed out after %0d cycles waiting for %s", TIMEOUT, what));
      cycles++;
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////
  // one fill or eviction
  ////////////////////////////////////////

  task automatic run_op(input logic [7:0] kind, input cache_biu_pkg::adr_t adr,
                        input logic [LINE_W-1:0] wline, input logic [LINE_W-1:0] exp_line);
    cache_biu_pkg::adr_t base;
    cache_biu_pkg::adr_t exp_a;
    logic                is_fill;
    logic                exp_err;
    logic [LINE_W-1:0]   written;
    int                  start;
    int                  exp_count;
    is_fill = (kind == "F");
    base    = adr & ~cache_biu_pkg::adr_t'(LINE_BYTES - 1);
    start   = int'(adr % LINE_BYTES) / 4; // critical word
    exp_err = is_fill && err_adr_valid &&
              ((err_adr & ~cache_biu_pkg::adr_t'(LINE_BYTES - 1)) == base);
    adr_log.delete();
    data_log.delete();
    @(posedge clk_i);
    #2;
    fill_req_i   = is_fill;
    evict_req_i  = !is_fill;
    line_adr_i   = adr;
    evict_line_i = wline;
    @(posedge clk_i);
    #2;
    fill_req_i  = 1'b0; // sampled once
    evict_req_i = 1'b0;
    @(negedge clk_i);
    wait_for_high(SIG_MEM_REQ, "mem_req_o");
    if (is_fill && !(err_adr_valid && adr == err_adr))
    begin
      check_flag(in_biubuffer_o, 1'b0, "in_biubuffer_o before the word is fetched");
      wait_for_high(SIG_MEM_ACK, "mem_ack_i of the requested word");
      @(negedge clk_i);
      check_flag(in_biubuffer_o, 1'b1, "in_biubuffer_o after the word is fetched");
    end
    wait_for_high(SIG_DONE, "done_o");
    check_flag(err_o, exp_err, "err_o");
    if (is_fill && !exp_err) check_line(line_o, exp_line, "line_o");
    // wrap from the critical word on a fill, ascending on an eviction
    exp_count = BURST_LEN;
    for (int i = 0; i < BURST_LEN; i++)
    begin
      if (is_fill) exp_a = base + cache_biu_pkg::adr_t'(((start + i) % BURST_LEN) * 4);
      else         exp_a = base + cache_biu_pkg::adr_t'(i * 4);
      if (i >= adr_log.size())
        stop_on_error($sformatf("memory saw only %0d words of the burst", adr_log.size()));
      check_adr(adr_log[i], exp_a, "mem_adr_o");
      if (exp_err && exp_a == err_adr)
      begin
        exp_count = i + 1; // burst ends on the error
        break;
      end
    end
    if (adr_log.size() != exp_count)
      stop_on_error($sformatf("memory saw %0d words, the burst has %0d",
                              adr_log.size(), exp_count));
    if (!is_fill)
    begin
      written = '0;
      foreach (data_log[i]) written[i*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] = data_log[i];
      check_line(written, wline, "line written to memory");
    end
    ops_run++;
  endtask

  initial
  begin : main
    int                  fd;
    int                  n;
    logic [7:0]          kind;
    cache_biu_pkg::adr_t adr;
    logic [LINE_W-1:0]   wline;
    logic [LINE_W-1:0]   exp_line;
    logic [8*256-1:0]    rest;
    rst_ni        = 1'b0;
    fill_req_i    = 1'b0;
    evict_req_i   = 1'b0;
    line_adr_i    = '0;
    evict_line_i  = '0;
    err_adr       = '0;
    err_adr_valid = 1'b0;
    ops_run       = 0;
    fd = $fopen("sim/cache_biu_patterns.txt", "r");
    if (fd == 0) stop_on_error("could not open sim/cache_biu_patterns.txt");
    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    while ($fscanf(fd, "%s", kind) == 1)
    begin
      if (kind == "#")
        n = $fgets(rest, fd); // comment line
      else
      begin
        n = $fscanf(fd, "%h %h %h", adr, wline, exp_line);
        if (n != 3) stop_on_error("a line of the pattern file is malformed");
        if (kind == "X")
        begin
          err_adr       = adr;
          err_adr_valid = 1'b1;
        end
        else
          run_op(kind, adr, wline, exp_line);
      end
    end
    $fclose(fd);
    if (ops_run > 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
      stop_on_error("the pattern file held no fill or eviction");
  end

endmodule

/* sim/cache_biu_patterns.txt */
# kind address write_line expected_line
# F fill, E evict, X error address; lines in hex, word 0 rightmost
F 00000108 00000000000000000000000000000000 FEF3010CFEF70108FEFB0104FEFF0100
F 00000204 00000000000000000000000000000000 FDF3020CFDF70208FDFB0204FDFF0200
E 0000030C 44444444333333332222222211111111 00000000000000000000000000000000
F 00000300 00000000000000000000000000000000 44444444333333332222222211111111
X 00000418 00000000000000000000000000000000 00000000000000000000000000000000
F 00000410 00000000000000000000000000000000 00000000000000000000000000000000
F 00000500 00000000000000000000000000000000 FAF3050CFAF70508FAFB0504FAFF0500
E 00000604 89ABCDEF0123456776543210FEDCBA98 00000000000000000000000000000000
F 0000060C 00000000000000000000000000000000 89ABCDEF0123456776543210FEDCBA98
F 0000010C 00000000000000000000000000000000 FEF3010CFEF70108FEFB0104FEFF0100

/* cache_biu.f */
logic/cache_biu_pkg.sv
logic/cache_mem_seq.sv
logic/cache_biu_ctrl.sv
logic/biu_burst_bridge.sv
logic/cache_biu_top.sv
sim/cache_biu_properties.sv
sim/cache_biu_tb.sv
